// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= dcache_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= No errors

SOURCES := $(wildcard design/*.sv design/*.svh bench/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary -Wno-fatal $(VFLAGS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bench/dcache_properties.sv ====
`timescale 1ns/1ps

module dcache_properties (
    input logic                    clk,
    input logic                    rst,
    input logic                    req,
    input logic                    busy,
    input logic                    resp_valid,
    input dcache_pkg::dc_axi_req_t axi_req,
    input dcache_pkg::dc_axi_rsp_t axi_rsp
);
    int unsigned fail_cnt = 0;  // failed assertions so far
    logic        rd_act;
    logic        wr_act;

    assign rd_act = axi_req.arvalid | axi_req.rready;
    assign wr_act = axi_req.awvalid | axi_req.wvalid | axi_req.bready;

    // valid and payload hold until the slave takes them
    ar_stable: assert property (@(posedge clk) disable iff (rst)
        axi_req.arvalid && !axi_rsp.arready |=> axi_req.arvalid && $stable(axi_req.araddr))
        else begin
            fail_cnt++;
            $error("AR channel changed while stalled");
        end

    aw_stable: assert property (@(posedge clk) disable iff (rst)
        axi_req.awvalid && !axi_rsp.awready |=> axi_req.awvalid && $stable(axi_req.awaddr))
        else begin
            fail_cnt++;
            $error("AW channel changed while stalled");
        end

    w_stable: assert property (@(posedge clk) disable iff (rst)
        axi_req.wvalid && !axi_rsp.wready
        |=> axi_req.wvalid && $stable(axi_req.wdata) && $stable(axi_req.wlast))
        else begin
            fail_cnt++;
            $error("W channel changed while stalled");
        end

    burst_len: assert property (@(posedge clk) disable iff (rst)
        (!axi_req.arvalid || axi_req.arlen == 4'd7) && (!axi_req.awvalid || axi_req.awlen == 4'd7))
        else begin
            fail_cnt++;
            $error("burst length is not 8 beats");
        end

    no_overlap: assert property (@(posedge clk) disable iff (rst) !(rd_act && wr_act))
        else begin
            fail_cnt++;
            $error("read and write bursts overlap");
        end

    // two cycles after req a hit answers or a miss has started a burst
    hit_latency: assert property (@(posedge clk) disable iff (rst)
        req |=> !resp_valid ##1 (resp_valid != (axi_req.arvalid || axi_req.awvalid)))
        else begin
            fail_cnt++;
            $error("hit latency is not 2 cycles");
        end

    resp_pulse: assert property (@(posedge clk) disable iff (rst) resp_valid |=> !resp_valid)
        else begin
            fail_cnt++;
            $error("resp_valid longer than one cycle");
        end

    // busy from the cycle after req through the resp_valid cycle
    busy_on: assert property (@(posedge clk) disable iff (rst)
        (req || (busy && !resp_valid)) |=> busy)
        else begin
            fail_cnt++;
            $error("busy low while a request is in progress");
        end

    busy_off: assert property (@(posedge clk) disable iff (rst)
        (!req && (!busy || resp_valid)) |=> !busy)
        else begin
            fail_cnt++;
            $error("busy high with no request in progress");
        end

endmodule

bind dcache_top dcache_properties u_props (
    .clk        (clk),
    .rst        (rst),
    .req        (req),
    .busy       (busy),
    .resp_valid (resp_valid),
    .axi_req    (axi_req),
    .axi_rsp    (axi_rsp)
);

// ==== bench/dcache_tb.sv ====
`timescale 1ns/1ps

module dcache_tb;
    import dcache_pkg::*;

    localparam logic [31:0] SEED      = 32'h4463_0913;
    localparam int          MEM_WORDS = 4096;   // 16 KB behind the cache
    localparam int          TIMEOUT   = 2000;
    // expected victim ways of five fills in one set with the first fill lowest
    localparam logic [9:0]  WAY_ORDER = {2'd0, 2'd3, 2'd1, 2'd2, 2'd0};

    logic        clk = 1'b0;
    logic        rst;
    logic        req;
    dc_req_t     req_info;
    logic        busy;
    logic        resp_valid;
    logic [31:0] rdata;
    dc_axi_req_t axi_req;
    dc_axi_rsp_t axi_rsp = '0;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] ref_mem [MEM_WORDS];   // every byte the CPU has stored
    logic [31:0] bp_rnd = SEED;
    logic [31:0] stim_rnd = SEED;
    logic        rd_on;
    logic        b_pend;
    logic [11:0] rd_ptr;
    logic [11:0] wr_ptr;
    logic [2:0]  rd_n;
    logic [2:0]  wr_n;
    logic [31:0] last_ar;
    logic [31:0] last_aw;
    time         ar_time;
    time         aw_time;
    int          ar_cnt;
    int          aw_cnt;
    int          r_beats;
    int          w_beats;
    int          errors = 0;
    int          checks = 0;
    int          tests = 0;
    int          test_err = 0;
    int          lat;
    bit          stuck = 1'b0;

    always #4 clk = ~clk;

    dcache_top u_dut (
        .clk, .rst, .req, .req_info, .busy, .resp_valid, .rdata, .axi_req, .axi_rsp
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] fill_word(input int i);
        return 32'hA500_0000 ^ (32'(i) << 2) ^ (32'(i) << 20);
    endfunction

    // memory slave with random ready and valid stalls
    always @(posedge clk) begin
        bp_rnd = xorshift(bp_rnd);
        if (rst) begin
            for (int i = 0; i < MEM_WORDS; i++) mem[i] <= fill_word(i);
            axi_rsp <= '0;
            rd_on   <= 1'b0;
            b_pend  <= 1'b0;
            ar_cnt  <= 0;
            aw_cnt  <= 0;
            r_beats <= 0;
            w_beats <= 0;
        end else begin
            axi_rsp.arready <= bp_rnd[0] | bp_rnd[1];
            axi_rsp.awready <= bp_rnd[2] | bp_rnd[3];
            axi_rsp.wready  <= bp_rnd[4] | bp_rnd[5];
            if (axi_req.arvalid && axi_rsp.arready) begin
                rd_on   <= 1'b1;
                rd_ptr  <= axi_req.araddr[13:2];
                rd_n    <= '0;
                last_ar <= axi_req.araddr;
                ar_time <= $time;
                ar_cnt  <= ar_cnt + 1;
            end
            if (axi_rsp.rvalid && axi_req.rready) begin
                axi_rsp.rvalid <= 1'b0;
                rd_n           <= rd_n + 1'b1;
                r_beats        <= r_beats + 1;
                if (axi_rsp.rlast) rd_on <= 1'b0;
            end else if (rd_on && !axi_rsp.rvalid && bp_rnd[6]) begin
                axi_rsp.rvalid <= 1'b1;
                axi_rsp.rdata  <= mem[rd_ptr + 12'(rd_n)];
                axi_rsp.rlast  <= (rd_n == 3'd7);
            end
            if (axi_req.awvalid && axi_rsp.awready) begin
                wr_ptr  <= axi_req.awaddr[13:2];
                wr_n    <= '0;
                last_aw <= axi_req.awaddr;
                aw_time <= $time;
                aw_cnt  <= aw_cnt + 1;
            end
            if (axi_req.wvalid && axi_rsp.wready) begin
                check_word("wlast", 32'(axi_req.wlast), 32'(wr_n == 3'd7));
                mem[wr_ptr + 12'(wr_n)] <= axi_req.wdata;
                wr_n    <= wr_n + 1'b1;
                w_beats <= w_beats + 1;
                if (axi_req.wlast) b_pend <= 1'b1;
            end
            if (axi_rsp.bvalid && axi_req.bready) begin
                axi_rsp.bvalid <= 1'b0;
                b_pend         <= 1'b0;
            end else if (b_pend && bp_rnd[7]) begin
                axi_rsp.bvalid <= 1'b1;
            end
        end
    end

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_true(input bit cond, input string what);
        checks++;
        assert (cond) else begin
            errors++;
            $display("%0t %s", $time, what);
        end
    endtask

    // call just after a rising edge and it returns just after the edge that samples resp_valid
    task automatic access(input logic wr, input logic [31:0] addr,
                          input logic [31:0] data, input logic [3:0] strb);
        if (stuck) return;
        req      <= 1'b1;
        req_info <= '{addr: addr, wdata: data, wstrb: strb, write: wr};
        @(posedge clk);
        req <= 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!resp_valid && lat < TIMEOUT);
        if (!resp_valid) begin
            stuck = 1'b1;
            errors++;
            $display("%0t no response from the cache within %0d cycles, rest skipped",
                     $time, TIMEOUT);
        end
    endtask

    task automatic load_check(input logic [31:0] addr);
        access(1'b0, addr, 32'h0, 4'h0);
        check_word("rdata", rdata, ref_mem[addr[13:2]]);
    endtask

    task automatic store_check(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) ref_mem[addr[13:2]][8*b +: 8] = data[8*b +: 8];
        end
        access(1'b1, addr, data, strb);
        check_word("rdata", rdata, ref_mem[addr[13:2]]);  // merged word
    endtask

    task automatic line_check(input logic [31:0] line);
        for (int i = 0; i < 8; i++) begin
            check_word("mem word", mem[line[13:2] + 12'(i)], ref_mem[line[13:2] + 12'(i)]);
        end
    endtask

    task automatic report_test(input string name);
        int now_err;
        now_err = errors + int'(u_dut.u_props.fail_cnt);
        tests++;
        $display("test %0d %s: %s", tests, name, (now_err == test_err) ? "pass" : "fail");
        test_err = now_err;
    endtask

    initial begin
        logic [31:0] addr;
        logic [31:0] data;
        int          a0;
        int          r0;
        int          w0;
        int          b0;
        rst      = 1'b1;
        req      = 1'b0;
        req_info = '0;
        for (int i = 0; i < MEM_WORDS; i++) ref_mem[i] = fill_word(i);
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        a0 = ar_cnt;
        r0 = r_beats;
        load_check(32'h0000_042C);  // tag 2 in set 1
        check_word("ar count", 32'(ar_cnt - a0), 32'd1);
        check_word("araddr", last_ar, 32'h0000_0420);
        check_word("r beats", 32'(r_beats - r0), 32'd8);
        a0 = ar_cnt;
        load_check(32'h0000_0430);
        check_word("hit latency", 32'(lat), 32'd2);
        check_word("ar count", 32'(ar_cnt - a0), 32'd0);
        report_test("load miss then hit");

        a0 = ar_cnt;
        store_check(32'h0000_042C, 32'hDEAD_BEEF, 4'b0101);
        check_word("hit latency", 32'(lat), 32'd2);
        check_word("ar count", 32'(ar_cnt - a0), 32'd0);
        load_check(32'h0000_042C);
        report_test("store hit with strobes");

        a0 = ar_cnt;
        w0 = aw_cnt;
        store_check(32'h0000_0C48, 32'h1234_5678, 4'b1100);  // set 2 with a clean victim
        check_word("ar count", 32'(ar_cnt - a0), 32'd1);
        check_word("aw count", 32'(aw_cnt - w0), 32'd0);
        load_check(32'h0000_0C48);
        check_word("hit latency", 32'(lat), 32'd2);
        report_test("store miss with merge");

        // tags 1 to 5 into set 5 which is untouched since reset
        for (int t = 0; t < 5; t++) begin
            addr = 32'((t + 1) << 9) | 32'h0000_00A4;
            w0   = aw_cnt;
            b0   = w_beats;
            if (t == 0) begin
                store_check(addr, 32'hCAFE_F00D, 4'hF);
            end else begin
                load_check(addr);
            end
            check_word("victim_q", 32'(u_dut.u_ctrl.victim_q), 32'(WAY_ORDER[2*t +: 2]));
        end
        check_word("aw count", 32'(aw_cnt - w0), 32'd1);
        check_word("awaddr", last_aw, 32'h0000_02A0);
        check_word("w beats", 32'(w_beats - b0), 32'd8);
        check_word("araddr", last_ar, 32'h0000_0AA0);
        check_true(aw_time < ar_time, "refill read was issued before the writeback");
        line_check(32'h0000_02A0);
        load_check(32'h0000_02A4);  // back from memory
        report_test("lru order and dirty eviction");

        // tags 0 to 7 over sets 8 to 11
        for (int n = 0; n < 200; n++) begin
            stim_rnd = xorshift(stim_rnd);
            addr = {20'h0, stim_rnd[2:0], 2'b10, stim_rnd[4:3], stim_rnd[7:5], 2'b00};
            w0   = aw_cnt;
            if (stim_rnd[8]) begin
                data = xorshift(stim_rnd ^ 32'h5BD1_E995);
                store_check(addr, data, stim_rnd[12:9]);
            end else begin
                load_check(addr);
            end
            if (aw_cnt != w0) line_check(last_aw);
        end
        report_test("random traffic");

        $display("tests %0d checks %0d errors %0d assertion failures %0d",
                 tests, checks, errors, u_dut.u_props.fail_cnt);
        if (errors == 0 && u_dut.u_props.fail_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== design/dcache_axi_master.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_axi_master (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start_wb,
    input  logic                    start_refill,
    input  logic [`DC_ADDR_W-1:0]   line_addr,
    output logic [`DC_WORD_W-1:0]   wb_word,
    input  logic [31:0]             wb_data,
    output dcache_pkg::dc_beat_t    rbeat,
    output logic                    wb_done,
    output logic                    refill_done,
    output dcache_pkg::dc_axi_req_t axi_req,
    input  dcache_pkg::dc_axi_rsp_t axi_rsp
);
    logic [`DC_ADDR_W-1:0] line_q;   // shared, bursts never overlap
    logic                  rd_req;
    logic                  rd_addr_ok;
    logic [`DC_WORD_W-1:0] rd_cnt;
    logic                  wr_req;
    logic                  wr_addr_ok;
    logic                  wr_data_ok;
    logic [`DC_WORD_W-1:0] wr_cnt;

    logic ar_valid, w_valid, w_last;
    logic ar_hs, r_hs, aw_hs, w_hs, b_hs;

    assign ar_valid = rd_req & ~rd_addr_ok;
    assign w_valid  = wr_addr_ok & ~wr_data_ok;
    assign w_last   = (wr_cnt == `DC_WORD_W'(`DC_WORDS - 1));

    assign ar_hs = ar_valid & axi_rsp.arready;
    assign r_hs  = rd_addr_ok & axi_rsp.rvalid;
    assign aw_hs = wr_req & ~wr_addr_ok & axi_rsp.awready;
    assign w_hs  = w_valid & axi_rsp.wready;
    assign b_hs  = wr_data_ok & axi_rsp.bvalid;

    assign axi_req = '{
        araddr:  line_q,
        arlen:   4'(`DC_WORDS - 1),
        arvalid: ar_valid,
        rready:  rd_addr_ok,
        awaddr:  line_q,
        awlen:   4'(`DC_WORDS - 1),
        awvalid: wr_req & ~wr_addr_ok,
        wdata:   wb_data,
        wlast:   w_last,
        wvalid:  w_valid,
        bready:  wr_data_ok
    };

    assign rbeat   = '{valid: r_hs, word: rd_cnt, data: axi_rsp.rdata};
    assign wb_word = wr_cnt;

    always_ff @(posedge clk) begin
        if (start_wb || start_refill) line_q <= line_addr;
    end

    // read burst
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_req      <= 1'b0;
            rd_addr_ok  <= 1'b0;
            rd_cnt      <= '0;
            refill_done <= 1'b0;
        end else begin
            refill_done <= r_hs & axi_rsp.rlast;
            if (start_refill) rd_req <= 1'b1;
            if (ar_hs) rd_addr_ok <= 1'b1;
            if (r_hs) rd_cnt <= rd_cnt + 1'b1;   // wraps to 0 after beat 7
            if (r_hs && axi_rsp.rlast) begin
                rd_req     <= 1'b0;
                rd_addr_ok <= 1'b0;
            end
        end
    end

    // write burst, B closes it
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_req     <= 1'b0;
            wr_addr_ok <= 1'b0;
            wr_data_ok <= 1'b0;
            wr_cnt     <= '0;
            wb_done    <= 1'b0;
        end else begin
            wb_done <= b_hs;
            if (start_wb) wr_req <= 1'b1;
            if (aw_hs) wr_addr_ok <= 1'b1;
            if (w_hs) begin
                wr_cnt <= wr_cnt + 1'b1;
                if (w_last) wr_data_ok <= 1'b1;
            end
            if (b_hs) begin
                wr_req     <= 1'b0;
                wr_addr_ok <= 1'b0;
                wr_data_ok <= 1'b0;
            end
        end
    end

endmodule

// ==== design/dcache_ctrl.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    input  dcache_pkg::dc_req_t    req_info,
    output logic                   busy,
    output logic                   resp_valid,
    output logic [31:0]            rdata,
    input  dcache_pkg::dc_lookup_t lookup,
    output logic [`DC_INDEX_W-1:0] index,
    output logic [`DC_TAG_W-1:0]   tag,
    output logic                   touch,
    output logic [`DC_WAY_W-1:0]   touch_way,
    output logic                   fill,
    output logic                   fill_dirty,
    output logic                   mark_dirty,
    output logic [`DC_WAY_W-1:0]   mark_way,
    output logic                   hit_we,
    output logic [`DC_WAY_W-1:0]   hit_way,
    output logic [`DC_WORD_W-1:0]  word,
    output logic [3:0]             wstrb,
    output logic [31:0]            wdata,
    output logic [`DC_WAY_W-1:0]   refill_way,
    output logic                   merge_en,
    output logic [`DC_WORD_W-1:0]  merge_word,
    output logic [`DC_WAY_W-1:0]   rd_way,
    output logic [`DC_WORD_W-1:0]  rd_word,
    input  logic [31:0]            rd_data,
    input  logic [`DC_WORD_W-1:0]  wb_word,
    output logic                   start_wb,
    output logic                   start_refill,
    output logic [`DC_ADDR_W-1:0]  line_addr,
    input  logic                   wb_done,
    input  logic                   refill_done
);
    import dcache_pkg::*;

    dc_state_e            state;
    dc_req_t              req_q;
    logic [`DC_WAY_W-1:0] victim_q;
    logic                 lk_hit;
    logic                 lk_miss;
    logic                 done_fill;
    logic [31:0]          resp_word;

    assign index = req_q.addr[`DC_INDEX_W+`DC_OFFSET_W-1:`DC_OFFSET_W];
    assign tag   = req_q.addr[`DC_ADDR_W-1:`DC_INDEX_W+`DC_OFFSET_W];
    assign word  = req_q.addr[`DC_OFFSET_W-1:2];

    assign lk_hit    = (state == LOOKUP) & lookup.hit;
    assign lk_miss   = (state == LOOKUP) & ~lookup.hit;
    assign done_fill = (state == REFILL) & refill_done;

    assign busy       = (state != IDLE);
    assign resp_valid = (state == RESPOND);

    // tag store updates
    assign touch      = lk_hit | done_fill;
    assign touch_way  = lk_hit ? lookup.hit_way : victim_q;
    assign fill       = done_fill;
    assign fill_dirty = req_q.write;
    assign mark_dirty = lk_hit & req_q.write;
    assign mark_way   = lookup.hit_way;

    // data store control
    assign hit_we     = lk_hit & req_q.write;
    assign hit_way    = lookup.hit_way;
    assign wstrb      = req_q.wstrb;
    assign wdata      = req_q.wdata;
    assign refill_way = victim_q;
    assign merge_en   = (state == REFILL) & req_q.write;
    assign merge_word = word;
    assign rd_way     = (state == LOOKUP) ? lookup.hit_way : victim_q;
    assign rd_word    = (state == WRITEBACK) ? wb_word : word;

    assign start_wb     = lk_miss & lookup.victim_dirty;
    assign start_refill = (lk_miss & ~lookup.victim_dirty) | ((state == WRITEBACK) & wb_done);
    assign line_addr    = start_wb ? {lookup.victim_tag, index, `DC_OFFSET_W'(0)}
                                   : {tag, index, `DC_OFFSET_W'(0)};

    // word as it stands once the store lands
    always_comb begin
        resp_word = rd_data;
        for (int b = 0; b < 4; b++) begin
            if (req_q.write && req_q.wstrb[b]) resp_word[8*b +: 8] = req_q.wdata[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req) req_q <= req_info;
        if (lk_miss) victim_q <= lookup.victim_way;
        if (lk_hit || done_fill) rdata <= resp_word;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:      if (req) state <= LOOKUP;
                LOOKUP:    state <= lookup.hit ? RESPOND
                                  : (lookup.victim_dirty ? WRITEBACK : REFILL);
                WRITEBACK: if (wb_done) state <= REFILL;
                REFILL:    if (refill_done) state <= RESPOND;
                RESPOND:   state <= IDLE;
                default:   state <= IDLE;
            endcase
        end
    end

endmodule

// ==== design/dcache_data_store.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_data_store (
    input  logic                   clk,
    input  logic [`DC_INDEX_W-1:0] index,
    input  logic                   hit_we,
    input  logic [`DC_WAY_W-1:0]   hit_way,
    input  logic [`DC_WORD_W-1:0]  word,
    input  logic [3:0]             wstrb,
    input  logic [31:0]            wdata,
    input  dcache_pkg::dc_beat_t   rbeat,
    input  logic [`DC_WAY_W-1:0]   refill_way,
    input  logic                   merge_en,
    input  logic [`DC_WORD_W-1:0]  merge_word,
    input  logic [`DC_WAY_W-1:0]   rd_way,
    input  logic [`DC_WORD_W-1:0]  rd_word,
    output logic [31:0]            rd_data
);
    localparam int SETS = 1 << `DC_INDEX_W;

    logic [31:0] mem [`DC_WAYS][SETS][`DC_WORDS];

    logic                  wr_en;
    logic                  use_strb;
    logic [`DC_WAY_W-1:0]  wr_way;
    logic [`DC_WORD_W-1:0] wr_word;
    logic [31:0]           base;
    logic [31:0]           new_word;

    // store hit has priority, refill beats never coincide with it
    assign wr_en    = hit_we | rbeat.valid;
    assign wr_way   = hit_we ? hit_way : refill_way;
    assign wr_word  = hit_we ? word : rbeat.word;
    assign base     = hit_we ? mem[hit_way][index][word] : rbeat.data;
    assign use_strb = hit_we | (merge_en & (rbeat.word == merge_word));

    always_comb begin
        new_word = base;
        for (int b = 0; b < 4; b++) begin
            if (use_strb && wstrb[b]) new_word[8*b +: 8] = wdata[8*b +: 8];
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_way][index][wr_word] <= new_word;
    end

    assign rd_data = mem[rd_way][index][rd_word];  // response and writeback

endmodule

// ==== design/dcache_defines.svh ====
`ifndef DCACHE_DEFINES_SVH
`define DCACHE_DEFINES_SVH

// byte address and its split into tag / index / offset
`define DC_ADDR_W   32
`define DC_INDEX_W  4
`define DC_OFFSET_W 5
`define DC_TAG_W    23

// associativity
`define DC_WAYS     4
`define DC_WAY_W    2

// words per line, one per burst beat
`define DC_WORDS    8
`define DC_WORD_W   3

`endif

// ==== design/dcache_pkg.sv ====
`include "dcache_defines.svh"

package dcache_pkg;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WRITEBACK,
        REFILL,
        RESPOND
    } dc_state_e;

    typedef struct packed {
        logic [`DC_ADDR_W-1:0] addr;
        logic [31:0]           wdata;
        logic [3:0]            wstrb;
        logic                  write;   // 0 = load
    } dc_req_t;

    typedef struct packed {
        logic                 hit;
        logic [`DC_WAY_W-1:0] hit_way;
        logic [`DC_WAY_W-1:0] victim_way;
        logic                 victim_dirty;
        logic [`DC_TAG_W-1:0] victim_tag;
    } dc_lookup_t;

    // refill beat as written into the line
    typedef struct packed {
        logic                  valid;
        logic [`DC_WORD_W-1:0] word;
        logic [31:0]           data;
    } dc_beat_t;

    typedef struct packed {
        logic [`DC_ADDR_W-1:0] araddr;
        logic [3:0]            arlen;
        logic                  arvalid;
        logic                  rready;
        logic [`DC_ADDR_W-1:0] awaddr;
        logic [3:0]            awlen;
        logic                  awvalid;
        logic [31:0]           wdata;
        logic                  wlast;
        logic                  wvalid;
        logic                  bready;
    } dc_axi_req_t;

    typedef struct packed {
        logic        arready;
        logic [31:0] rdata;
        logic        rlast;
        logic        rvalid;
        logic        awready;
        logic        wready;
        logic        bvalid;
    } dc_axi_rsp_t;

endpackage

// ==== design/dcache_tag_store.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_tag_store (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [`DC_INDEX_W-1:0] index,
    input  logic [`DC_TAG_W-1:0]   tag,
    input  logic                   touch,
    input  logic [`DC_WAY_W-1:0]   touch_way,
    input  logic                   fill,
    input  logic                   fill_dirty,
    input  logic                   mark_dirty,
    input  logic [`DC_WAY_W-1:0]   mark_way,
    output dcache_pkg::dc_lookup_t lookup
);
    localparam int SETS = 1 << `DC_INDEX_W;

    logic [`DC_TAG_W-1:0] tags [`DC_WAYS][SETS];
    logic [SETS-1:0]      valid_q [`DC_WAYS];
    logic [SETS-1:0]      dirty_q [`DC_WAYS];
    logic [2:0]           lru [SETS];  // [0] half, [1] ways 0-1, [2] ways 2-3

    logic [`DC_WAYS-1:0]  match;
    logic [`DC_WAY_W-1:0] hit_way;
    logic [`DC_WAY_W-1:0] victim;
    logic [2:0]           lru_set;

    // one-hot tag match, then encoded
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            match[w] = valid_q[w][index] && (tags[w][index] == tag);
            if (match[w]) hit_way = `DC_WAY_W'(w);
        end
    end

    assign lru_set = lru[index];
    assign victim  = {lru_set[0], lru_set[0] ? lru_set[2] : lru_set[1]};

    assign lookup.hit          = |match;
    assign lookup.hit_way      = hit_way;
    assign lookup.victim_way   = victim;
    assign lookup.victim_dirty = valid_q[victim][index] & dirty_q[victim][index];
    assign lookup.victim_tag   = tags[victim][index];

    always_ff @(posedge clk) begin
        if (fill) tags[victim][index] <= tag;  // line replaced into victim way
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < `DC_WAYS; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
            for (int s = 0; s < SETS; s++) begin
                lru[s] <= '0;
            end
        end else begin
            if (fill) begin
                valid_q[victim][index] <= 1'b1;
                dirty_q[victim][index] <= fill_dirty;
            end
            if (mark_dirty) dirty_q[mark_way][index] <= 1'b1;
            // point the tree away from the touched way
            if (touch) begin
                lru[index][0] <= ~touch_way[1];
                if (touch_way[1]) begin
                    lru[index][2] <= ~touch_way[0];
                end else begin
                    lru[index][1] <= ~touch_way[0];
                end
            end
        end
    end

endmodule

// ==== design/dcache_top.sv ====
`timescale 1ns/1ps
`include "dcache_defines.svh"

module dcache_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    req,
    input  dcache_pkg::dc_req_t     req_info,
    output logic                    busy,
    output logic                    resp_valid,
    output logic [31:0]             rdata,
    output dcache_pkg::dc_axi_req_t axi_req,
    input  dcache_pkg::dc_axi_rsp_t axi_rsp
);
    import dcache_pkg::*;

    dc_lookup_t            lookup;
    dc_beat_t              rbeat;
    logic [`DC_INDEX_W-1:0] index;
    logic [`DC_TAG_W-1:0]  tag;
    logic                  touch, fill, fill_dirty, mark_dirty;
    logic [`DC_WAY_W-1:0]  touch_way, mark_way;
    logic                  hit_we, merge_en;
    logic [`DC_WAY_W-1:0]  hit_way, refill_way, rd_way;
    logic [`DC_WORD_W-1:0] word, merge_word, rd_word, wb_word;
    logic [3:0]            wstrb;
    logic [31:0]           wdata, rd_data;
    logic                  start_wb, start_refill, wb_done, refill_done;
    logic [`DC_ADDR_W-1:0] line_addr;

    dcache_ctrl u_ctrl (
        .clk, .rst, .req, .req_info, .busy, .resp_valid, .rdata,
        .lookup, .index, .tag, .touch, .touch_way, .fill, .fill_dirty,
        .mark_dirty, .mark_way, .hit_we, .hit_way, .word, .wstrb, .wdata,
        .refill_way, .merge_en, .merge_word, .rd_way, .rd_word, .rd_data,
        .wb_word, .start_wb, .start_refill, .line_addr, .wb_done, .refill_done
    );

    dcache_tag_store u_tags (
        .clk, .rst, .index, .tag, .touch, .touch_way, .fill, .fill_dirty,
        .mark_dirty, .mark_way, .lookup
    );

    dcache_data_store u_data (
        .clk, .index, .hit_we, .hit_way, .word, .wstrb, .wdata,
        .rbeat, .refill_way, .merge_en, .merge_word, .rd_way, .rd_word, .rd_data
    );

    // writeback data comes straight off the data store read port
    dcache_axi_master u_axi (
        .clk, .rst, .start_wb, .start_refill, .line_addr, .wb_word,
        .wb_data     (rd_data),
        .rbeat, .wb_done, .refill_done, .axi_req, .axi_rsp
    );

endmodule

// ==== filelist.f ====
+incdir+design
design/dcache_pkg.sv
design/dcache_tag_store.sv
design/dcache_data_store.sv
design/dcache_ctrl.sv
design/dcache_axi_master.sv
design/dcache_top.sv
bench/dcache_properties.sv
bench/dcache_tb.sv
